// File: alpha_int_core.f
design/alpha_pkg.sv
design/instn_decode.sv
design/regfile.sv
design/addsub.sv
design/logical.sv
design/shift_unit.sv
design/issue_grad.sv
design/alpha_int_core.sv
sim/alpha_int_core_sva.sv
sim/tb_alpha_int_core.sv

// File: design/addsub.sv
`timescale 1ns/1ps
`default_nettype none

module addsub
   import alpha_pkg::*;
(
   input  logic       clk,
   input  logic       rst,
   input  logic       en,
   input  addsub_op_e op,
   input  operands_t  opnd,
   output unit_res_t  res
);

   word_t result;
   logic  vld_q;
   word_t data_q;

   always_comb
   begin
      case (op)
         add:     result = opnd.op_a + opnd.op_b;
         sub:     result = opnd.op_a - opnd.op_b;
         s4add:   result = (opnd.op_a << 2) + opnd.op_b;
         s8add:   result = (opnd.op_a << 3) + opnd.op_b;
         cmpeq:   result = {{(xlen-1){1'b0}}, opnd.op_a == opnd.op_b};
         cmplt:   result = {{(xlen-1){1'b0}}, $signed(opnd.op_a) < $signed(opnd.op_b)};
         cmpult:  result = {{(xlen-1){1'b0}}, opnd.op_a < opnd.op_b};
         default: result = '0;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (rst)
         vld_q <= 1'b0;
      else
         vld_q <= en;
   end

   always_ff @(posedge clk)
      if (en)
         data_q <= result;

   assign res.vld  = vld_q;
   assign res.data = data_q;

endmodule

`default_nettype wire

// File: design/alpha_int_core.sv
`timescale 1ns/1ps
`default_nettype none

module alpha_int_core
   import alpha_pkg::*;
(
   input  logic        clk,
   input  logic        rst,
   input  logic        instn_vld,
   input  logic [31:0] instn,
   output logic        instn_ready,
   output grad_t       grad
);

   decoded_t  dec;
   word_t     rd_data_a;
   word_t     rd_data_b;
   logic      en_addsub;
   logic      en_logic;
   logic      en_shift;
   exec_op_t  exec_op;
   operands_t opnd;
   unit_res_t res_addsub;
   unit_res_t res_logic;
   unit_res_t res_shift;

   instn_decode idecode (
      .instn (instn),
      .dec   (dec)
   );

   issue_grad igu (
      .clk         (clk),
      .rst         (rst),
      .instn_vld   (instn_vld),
      .dec         (dec),
      .rd_data_b   (rd_data_b),
      .rd_data_a   (rd_data_a),
      .instn_ready (instn_ready),
      .en_addsub   (en_addsub),
      .en_logic    (en_logic),
      .en_shift    (en_shift),
      .exec_op     (exec_op),
      .opnd        (opnd),
      .res_addsub  (res_addsub),
      .res_logic   (res_logic),
      .res_shift   (res_shift),
      .grad        (grad)
   );

   // Read addresses come straight from decode
   regfile rf (
      .clk       (clk),
      .rst       (rst),
      .rd_addr_a (dec.ra),
      .rd_addr_b (dec.rb),
      .wr        (grad),
      .rd_data_a (rd_data_a),
      .rd_data_b (rd_data_b)
   );

   addsub alu (
      .clk  (clk),
      .rst  (rst),
      .en   (en_addsub),
      .op   (exec_op.addsub),
      .opnd (opnd),
      .res  (res_addsub)
   );

   logical lgc (
      .clk  (clk),
      .rst  (rst),
      .en   (en_logic),
      .op   (exec_op.log),
      .opnd (opnd),
      .res  (res_logic)
   );

   shift_unit shf (
      .clk  (clk),
      .rst  (rst),
      .en   (en_shift),
      .op   (exec_op.shift),
      .opnd (opnd),
      .res  (res_shift)
   );

endmodule

`default_nettype wire

// File: design/alpha_pkg.sv
`default_nettype none

package alpha_pkg;

   localparam int xlen     = 64;
   localparam int nreg     = 32;
   localparam int reg_zero = 31;

   typedef logic [4:0]      reg_idx_t;
   typedef logic [xlen-1:0] word_t;

   // Operate format opcode groups
   localparam logic [5:0] op_inta = 6'h10;
   localparam logic [5:0] op_intl = 6'h11;
   localparam logic [5:0] op_ints = 6'h12;

   // Integer arithmetic functions
   localparam logic [6:0] fn_addq   = 7'h20;
   localparam logic [6:0] fn_subq   = 7'h29;
   localparam logic [6:0] fn_s4addq = 7'h22;
   localparam logic [6:0] fn_s8addq = 7'h32;
   localparam logic [6:0] fn_cmpeq  = 7'h2d;
   localparam logic [6:0] fn_cmplt  = 7'h4d;
   localparam logic [6:0] fn_cmpult = 7'h1d;

   // Logical functions
   localparam logic [6:0] fn_and    = 7'h00;
   localparam logic [6:0] fn_bic    = 7'h08;
   localparam logic [6:0] fn_bis    = 7'h20;
   localparam logic [6:0] fn_ornot  = 7'h28;
   localparam logic [6:0] fn_xor    = 7'h40;
   localparam logic [6:0] fn_eqv    = 7'h48;

   // Shift functions
   localparam logic [6:0] fn_sll    = 7'h39;
   localparam logic [6:0] fn_srl    = 7'h34;
   localparam logic [6:0] fn_sra    = 7'h3c;

   typedef enum logic [1:0] {fu_none, fu_addsub, fu_logic, fu_shift} funit_e;

   typedef enum logic [2:0] {add, sub, s4add, s8add, cmpeq, cmplt, cmpult} addsub_op_e;

   typedef enum logic [2:0] {and_op, bic, bis, ornot, xor_op, eqv} log_op_e;

   typedef enum logic [1:0] {sll, srl, sra} shift_op_e;

   typedef struct packed {
      addsub_op_e addsub;
      log_op_e    log;
      shift_op_e  shift;
   } exec_op_t;

   typedef struct packed {
      funit_e     funit;
      reg_idx_t   ra;
      reg_idx_t   rb;
      reg_idx_t   rc;
      logic       use_lit;
      logic [7:0] lit;
      logic       writes_rf;
      exec_op_t   op;
   } decoded_t;

   typedef struct packed {
      word_t op_a;
      word_t op_b;
   } operands_t;

   typedef struct packed {
      logic  vld;
      word_t data;
   } unit_res_t;

   typedef struct packed {
      logic     retire;
      logic     wen;
      reg_idx_t waddr;
      word_t    wdata;
   } grad_t;

endpackage

`default_nettype wire

// File: design/instn_decode.sv
`timescale 1ns/1ps
`default_nettype none

module instn_decode
   import alpha_pkg::*;
(
   input  logic [31:0] instn,
   output decoded_t    dec
);

   logic [5:0] opcode;
   logic [6:0] func;

   assign opcode = instn[31:26];
   assign func   = instn[11:5];

   always_comb
   begin
      dec         = '0;
      dec.ra      = instn[25:21];
      dec.rb      = instn[20:16];
      dec.use_lit = instn[12];
      dec.lit     = instn[20:13];
      dec.rc      = instn[4:0];

      case (opcode)
         op_inta:
         begin
            dec.funit = fu_addsub;
            case (func)
               fn_addq:   dec.op.addsub = add;
               fn_subq:   dec.op.addsub = sub;
               fn_s4addq: dec.op.addsub = s4add;
               fn_s8addq: dec.op.addsub = s8add;
               fn_cmpeq:  dec.op.addsub = cmpeq;
               fn_cmplt:  dec.op.addsub = cmplt;
               fn_cmpult: dec.op.addsub = cmpult;
               default:   dec.funit     = fu_none;
            endcase
         end
         op_intl:
         begin
            dec.funit = fu_logic;
            case (func)
               fn_and:   dec.op.log = and_op;
               fn_bic:   dec.op.log = bic;
               fn_bis:   dec.op.log = bis;
               fn_ornot: dec.op.log = ornot;
               fn_xor:   dec.op.log = xor_op;
               fn_eqv:   dec.op.log = eqv;
               default:  dec.funit  = fu_none;
            endcase
         end
         op_ints:
         begin
            dec.funit = fu_shift;
            case (func)
               fn_sll:  dec.op.shift = sll;
               fn_srl:  dec.op.shift = srl;
               fn_sra:  dec.op.shift = sra;
               default: dec.funit    = fu_none;
            endcase
         end
         default:
            dec.funit = fu_none;
      endcase

      // Reserved pairs and r31 targets leave the register file alone
      dec.writes_rf = (dec.funit != fu_none) && (dec.rc != reg_idx_t'(reg_zero));
   end

endmodule

`default_nettype wire

// File: design/issue_grad.sv
`timescale 1ns/1ps
`default_nettype none

module issue_grad
   import alpha_pkg::*;
(
   input  logic      clk,
   input  logic      rst,
   input  logic      instn_vld,
   input  decoded_t  dec,
   input  word_t     rd_data_b,
   input  word_t     rd_data_a,
   output logic      instn_ready,
   output logic      en_addsub,
   output logic      en_logic,
   output logic      en_shift,
   output exec_op_t  exec_op,
   output operands_t opnd,
   input  unit_res_t res_addsub,
   input  unit_res_t res_logic,
   input  unit_res_t res_shift,
   output grad_t     grad
);

   logic       accept;
   logic       hit_a;
   logic       hit_b;

   // e0 stage
   logic       e0_vld;
   logic       e0_wr;
   funit_e     e0_funit;
   exec_op_t   e0_op;
   reg_idx_t   e0_rc;
   logic       e0_use_lit;
   logic [7:0] e0_lit;

   // e1 stage
   logic       e1_vld;
   logic       e1_wr;
   reg_idx_t   e1_rc;

   // Only the e0 entry can be missed by the read; e1 is covered by write-through
   assign hit_a       = (e0_rc == dec.ra);
   assign hit_b       = !dec.use_lit && (e0_rc == dec.rb);
   assign instn_ready = !(e0_vld && e0_wr && (hit_a || hit_b));
   assign accept      = instn_vld && instn_ready;

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         e0_vld <= 1'b0;
         e0_wr  <= 1'b0;
      end
      else
      begin
         e0_vld <= accept;
         if (accept)
            e0_wr <= dec.writes_rf;
      end
   end

   always_ff @(posedge clk)
   begin
      if (accept)
      begin
         e0_funit   <= dec.funit;
         e0_op      <= dec.op;
         e0_rc      <= dec.rc;
         e0_use_lit <= dec.use_lit;
         e0_lit     <= dec.lit;
      end
   end

   assign en_addsub = e0_vld && (e0_funit == fu_addsub);
   assign en_logic  = e0_vld && (e0_funit == fu_logic);
   assign en_shift  = e0_vld && (e0_funit == fu_shift);
   assign exec_op   = e0_op;

   // 8-bit literal is zero extended in place of rb
   assign opnd.op_a = rd_data_a;
   assign opnd.op_b = e0_use_lit ? {{(xlen-8){1'b0}}, e0_lit} : rd_data_b;

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         e1_vld <= 1'b0;
         e1_wr  <= 1'b0;
      end
      else
      begin
         e1_vld <= e0_vld;
         e1_wr  <= e0_vld && e0_wr;
      end
   end

   always_ff @(posedge clk)
      e1_rc <= e0_rc;

   assign grad.retire = e1_vld;
   assign grad.wen    = e1_wr;
   assign grad.waddr  = e1_rc;

   // At most one unit reports per cycle
   assign grad.wdata  = ({xlen{res_addsub.vld}} & res_addsub.data)
                      | ({xlen{res_logic.vld}}  & res_logic.data)
                      | ({xlen{res_shift.vld}}  & res_shift.data);

endmodule

`default_nettype wire

// File: design/logical.sv
`timescale 1ns/1ps
`default_nettype none

module logical
   import alpha_pkg::*;
(
   input  logic      clk,
   input  logic      rst,
   input  logic      en,
   input  log_op_e   op,
   input  operands_t opnd,
   output unit_res_t res
);

   word_t result;
   logic  vld_q;
   word_t data_q;

   always_comb
   begin
      case (op)
         and_op:  result = opnd.op_a & opnd.op_b;
         bic:     result = opnd.op_a & ~opnd.op_b;
         bis:     result = opnd.op_a | opnd.op_b;
         ornot:   result = opnd.op_a | ~opnd.op_b;
         xor_op:  result = opnd.op_a ^ opnd.op_b;
         eqv:     result = ~(opnd.op_a ^ opnd.op_b);
         default: result = '0;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (rst)
         vld_q <= 1'b0;
      else
         vld_q <= en;
   end

   always_ff @(posedge clk)
      if (en)
         data_q <= result;

   assign res.vld  = vld_q;
   assign res.data = data_q;

endmodule

`default_nettype wire

// File: design/regfile.sv
`timescale 1ns/1ps
`default_nettype none

module regfile
   import alpha_pkg::*;
(
   input  logic     clk,
   input  logic     rst,
   input  reg_idx_t rd_addr_a,
   input  reg_idx_t rd_addr_b,
   input  grad_t    wr,
   output word_t    rd_data_a,
   output word_t    rd_data_b
);

   word_t mem [nreg];

   // r31 is hardwired zero; a write on the same edge is forwarded
   function automatic word_t read_port(input reg_idx_t addr);
      word_t val;
      if (addr == reg_idx_t'(reg_zero))
         val = '0;
      else if (wr.wen && (wr.waddr == addr))
         val = wr.wdata;
      else
         val = mem[addr];
      return val;
   endfunction

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         for (int i = 0; i < nreg; i++)
            mem[i] <= '0;
         rd_data_a <= '0;
         rd_data_b <= '0;
      end
      else
      begin
         if (wr.wen)
            mem[wr.waddr] <= wr.wdata;
         rd_data_a <= read_port(rd_addr_a);
         rd_data_b <= read_port(rd_addr_b);
      end
   end

endmodule

`default_nettype wire

// File: design/shift_unit.sv
`timescale 1ns/1ps
`default_nettype none

module shift_unit
   import alpha_pkg::*;
(
   input  logic      clk,
   input  logic      rst,
   input  logic      en,
   input  shift_op_e op,
   input  operands_t opnd,
   output unit_res_t res
);

   logic [5:0] shamt;
   word_t      result;
   logic       vld_q;
   word_t      data_q;

   // Only the low six bits of b count
   assign shamt = opnd.op_b[5:0];

   always_comb
   begin
      case (op)
         sll:     result = opnd.op_a << shamt;
         srl:     result = opnd.op_a >> shamt;
         sra:     result = word_t'($signed(opnd.op_a) >>> shamt);
         default: result = '0;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (rst)
         vld_q <= 1'b0;
      else
         vld_q <= en;
   end

   always_ff @(posedge clk)
      if (en)
         data_q <= result;

   assign res.vld  = vld_q;
   assign res.data = data_q;

endmodule

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_alpha_int_core \
   -f alpha_int_core.f

./obj_dir/Vtb_alpha_int_core 2>&1 | tee sim.log

grep -q "ALL TESTS PASSED" sim.log

// File: sim/alpha_int_core_sva.sv
`timescale 1ns/1ps
`default_nettype none

module alpha_int_core_sva
   import alpha_pkg::*;
(
   input logic  clk,
   input logic  rst,
   input logic  instn_vld,
   input logic  instn_ready,
   input grad_t grad
);

   logic accept;

   assign accept = instn_vld && instn_ready;

   // Two edges from issue to graduation, both ways
   retire_after_accept: assert property (@(posedge clk) disable iff (rst)
      accept |-> ##2 grad.retire)
      else $error("retire missing two cycles after acceptance");

   retire_has_source: assert property (@(posedge clk) disable iff (rst)
      grad.retire |-> $past(accept, 2))
      else $error("retire without an acceptance two cycles earlier");

   wen_needs_retire: assert property (@(posedge clk) disable iff (rst)
      grad.wen |-> grad.retire)
      else $error("write enable without retire");

   no_zero_write: assert property (@(posedge clk) disable iff (rst)
      grad.wen |-> (grad.waddr != reg_idx_t'(reg_zero)))
      else $error("write aimed at r31");

endmodule

bind alpha_int_core alpha_int_core_sva sva (
   .clk         (clk),
   .rst         (rst),
   .instn_vld   (instn_vld),
   .instn_ready (instn_ready),
   .grad        (grad)
);

`default_nettype wire

// File: sim/tb_alpha_int_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_alpha_int_core
   import alpha_pkg::*;
();

   typedef struct packed {
      logic [31:0] cycle;
      logic        wen;
      reg_idx_t    waddr;
      word_t       wdata;
   } expect_t;

   logic        clk;
   logic        rst;
   logic        instn_vld;
   logic [31:0] instn;
   logic        instn_ready;
   grad_t       grad;

   word_t       model_rf [nreg];
   expect_t     pending [$];
   logic [31:0] cycle;
   int          errors;
   int          checks;
   int          tests_run;
   int          tests_failed;
   logic        timed_out;

   // Last accepted instruction, in e0 during busy_cycle
   logic [31:0] busy_cycle;
   logic        busy_wr;
   reg_idx_t    busy_rc;

   alpha_int_core uut (
      .clk         (clk),
      .rst         (rst),
      .instn_vld   (instn_vld),
      .instn       (instn),
      .instn_ready (instn_ready),
      .grad        (grad)
   );

   initial
   begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   always @(posedge clk)
   begin
      if (rst)
         cycle <= '0;
      else
         cycle <= cycle + 1;
   end

   // Graduation monitor, sampled mid-cycle
   always @(negedge clk)
   begin
      expect_t entry;
      if (!rst)
      begin
         if (grad.wen && !grad.retire)
         begin
            errors++;
            $display("write enable high without a retiring instruction");
         end
         if (grad.retire)
         begin
            if (pending.size() == 0)
            begin
               errors++;
               $display("retire seen with no accepted instruction outstanding");
            end
            else
            begin
               entry = pending.pop_front();
               checks++;
               if (cycle != entry.cycle)
               begin
                  errors++;
                  $display("retire came at cycle %0d instead of cycle %0d", cycle, entry.cycle);
               end
               if (grad.wen != entry.wen)
               begin
                  errors++;
                  $display("mismatch grad.wen expected %h got %h", entry.wen, grad.wen);
               end
               else if (entry.wen)
               begin
                  if (grad.waddr != entry.waddr)
                  begin
                     errors++;
                     $display("mismatch grad.waddr expected %h got %h",
                              entry.waddr, grad.waddr);
                  end
                  if (grad.wdata != entry.wdata)
                  begin
                     errors++;
                     $display("mismatch grad.wdata expected %h got %h",
                              entry.wdata, grad.wdata);
                  end
               end
            end
         end
      end
   end

   function automatic logic [31:0] encode(input logic [5:0] opc, input reg_idx_t ra,
                                          input reg_idx_t rb, input logic use_lit,
                                          input logic [7:0] lit, input logic [6:0] fn,
                                          input reg_idx_t rc);
      logic [31:0] w;
      w        = '0;
      w[31:26] = opc;
      w[25:21] = ra;
      w[12]    = use_lit;
      w[11:5]  = fn;
      w[4:0]   = rc;
      if (use_lit)
         w[20:13] = lit;
      else
         w[20:16] = rb;
      return w;
   endfunction

   // Architectural result; vld clear for reserved encodings
   function automatic unit_res_t model_result(input logic [5:0] opc, input logic [6:0] fn,
                                              input word_t a, input word_t b);
      unit_res_t  r;
      logic [5:0] n;
      logic       lt;
      word_t      fill;
      r.vld  = 1'b1;
      r.data = '0;
      n      = b[5:0];
      lt     = (a[63] != b[63]) ? a[63] : (a < b);
      fill   = a[63] ? ~({xlen{1'b1}} >> n) : '0;
      case (opc)
         op_inta:
            case (fn)
               fn_addq:   r.data = a + b;
               fn_subq:   r.data = a - b;
               fn_s4addq: r.data = a * 4 + b;
               fn_s8addq: r.data = a * 8 + b;
               fn_cmpeq:  r.data = word_t'(a == b);
               fn_cmplt:  r.data = word_t'(lt);
               fn_cmpult: r.data = word_t'(a < b);
               default:   r.vld  = 1'b0;
            endcase
         op_intl:
            case (fn)
               fn_and:   r.data = a & b;
               fn_bic:   r.data = a & ~b;
               fn_bis:   r.data = a | b;
               fn_ornot: r.data = a | ~b;
               fn_xor:   r.data = a ^ b;
               fn_eqv:   r.data = ~(a ^ b);
               default:  r.vld  = 1'b0;
            endcase
         op_ints:
            case (fn)
               fn_sll:  r.data = a << n;
               fn_srl:  r.data = a >> n;
               fn_sra:  r.data = (a >> n) | fill;
               default: r.vld  = 1'b0;
            endcase
         default:
            r.vld = 1'b0;
      endcase
      if (!r.vld)
         r.data = '0;
      return r;
   endfunction

   task automatic record_accept(input logic [31:0] w);
      reg_idx_t  ra;
      reg_idx_t  rb;
      reg_idx_t  rc;
      word_t     a;
      word_t     b;
      unit_res_t r;
      expect_t   e;
      ra = w[25:21];
      rb = w[20:16];
      rc = w[4:0];
      a  = (ra == reg_idx_t'(reg_zero)) ? '0 : model_rf[ra];
      if (w[12])
         b = word_t'(w[20:13]);
      else
         b = (rb == reg_idx_t'(reg_zero)) ? '0 : model_rf[rb];
      r       = model_result(w[31:26], w[11:5], a, b);
      e.cycle = cycle + 2;
      e.wen   = r.vld && (rc != reg_idx_t'(reg_zero));
      e.waddr = rc;
      e.wdata = r.data;
      if (e.wen)
         model_rf[rc] = r.data;
      pending.push_back(e);
      busy_cycle = cycle + 1;
      busy_wr    = e.wen;
      busy_rc    = rc;
   endtask

   // Stall only on an e0 writer whose destination feeds this instruction
   task automatic check_ready(input logic [31:0] w);
      logic hit;
      logic exp_ready;
      hit       = (w[25:21] == busy_rc) || (!w[12] && (w[20:16] == busy_rc));
      exp_ready = !((cycle == busy_cycle) && busy_wr && hit);
      if (instn_ready != exp_ready)
      begin
         errors++;
         $display("mismatch instn_ready expected %h got %h", exp_ready, instn_ready);
      end
   endtask

   // Offer one instruction and hold it until the core takes it
   task automatic send(input logic [31:0] w, input int gap);
      int waited;
      if (!timed_out)
      begin
         repeat (gap)
         begin
            @(posedge clk);
            #1;
         end
         instn     = w;
         instn_vld = 1'b1;
         waited    = 0;
         @(negedge clk);
         check_ready(w);
         while (!instn_ready && waited < 20)
         begin
            waited++;
            @(negedge clk);
            check_ready(w);
         end
         if (!instn_ready)
         begin
            timed_out = 1'b1;
            $display("timeout: instruction %h was never accepted", w);
         end
         else
            record_accept(w);
         @(posedge clk);
         #1;
         instn_vld = 1'b0;
      end
   endtask

   task automatic drain();
      int waited;
      if (!timed_out)
      begin
         waited = 0;
         while (pending.size() != 0 && waited < 50)
         begin
            waited++;
            @(posedge clk);
         end
         if (pending.size() != 0)
         begin
            timed_out = 1'b1;
            $display("timeout: %0d graduations never arrived", pending.size());
         end
         @(posedge clk);
         #1;
      end
   endtask

   task automatic report_test(input string name, input int err_before);
      tests_run++;
      if (errors != err_before || timed_out)
      begin
         tests_failed++;
         $display("test %0d %s: failed with %0d errors", tests_run, name, errors - err_before);
      end
      else
         $display("test %0d %s: passed", tests_run, name);
   endtask

   // Sources lean on r1..r14, destinations on r8..r14
   function automatic reg_idx_t pick_src();
      int sel;
      sel = $urandom_range(0, 9);
      if (sel < 7)
         return reg_idx_t'($urandom_range(1, 14));
      else if (sel == 7)
         return reg_idx_t'(reg_zero);
      return reg_idx_t'($urandom_range(0, 31));
   endfunction

   function automatic reg_idx_t pick_dst();
      int sel;
      sel = $urandom_range(0, 19);
      if (sel < 15)
         return reg_idx_t'($urandom_range(8, 14));
      else if (sel < 17)
         return reg_idx_t'(reg_zero);
      return reg_idx_t'($urandom_range(0, 31));
   endfunction

   function automatic int pick_gap();
      if ($urandom_range(0, 9) < 6)
         return 0;
      return $urandom_range(1, 3);
   endfunction

   function automatic logic [31:0] gen_instn(input int group, input logic odd);
      logic [5:0] opc;
      logic [6:0] fn;
      opc = op_inta;
      fn  = fn_addq;
      case (group)
         0:
            case ($urandom_range(0, 6))
               0: fn = fn_addq;
               1: fn = fn_subq;
               2: fn = fn_s4addq;
               3: fn = fn_s8addq;
               4: fn = fn_cmpeq;
               5: fn = fn_cmplt;
               default: fn = fn_cmpult;
            endcase
         1:
         begin
            opc = op_intl;
            case ($urandom_range(0, 5))
               0: fn = fn_and;
               1: fn = fn_bic;
               2: fn = fn_bis;
               3: fn = fn_ornot;
               4: fn = fn_xor;
               default: fn = fn_eqv;
            endcase
         end
         default:
         begin
            opc = op_ints;
            case ($urandom_range(0, 2))
               0: fn = fn_sll;
               1: fn = fn_srl;
               default: fn = fn_sra;
            endcase
         end
      endcase
      // Unused function codes and the dropped multiply group
      if (odd && $urandom_range(0, 15) == 0)
         case ($urandom_range(0, 3))
            0: fn = 7'h7f;
            1: fn = 7'h01;
            2: fn = 7'h55;
            default: opc = 6'h13;
         endcase
      return encode(opc, pick_src(), pick_src(), $urandom_range(0, 3) == 0,
                    8'($urandom), fn, pick_dst());
   endfunction

   task automatic test_reset_idle();
      int err_before;
      err_before = errors;
      repeat (8)
      begin
         @(posedge clk);
         #1;
      end
      for (int i = 0; i < nreg; i++)
         send(encode(op_intl, reg_idx_t'(i), '0, 1'b1, 8'h00, fn_bis, reg_idx_t'(i)), 0);
      drain();
      report_test("reset and zero registers", err_before);
   endtask

   task automatic test_literal_build();
      int    err_before;
      word_t v;
      err_before = errors;
      for (int r = 1; r <= 14; r++)
      begin
         v = {$urandom, $urandom};
         send(encode(op_intl, reg_idx_t'(reg_zero), '0, 1'b1, v[63:56], fn_bis,
                     reg_idx_t'(r)), 0);
         for (int k = 6; k >= 0; k--)
         begin
            send(encode(op_ints, reg_idx_t'(r), '0, 1'b1, 8'd8, fn_sll, reg_idx_t'(r)), 0);
            send(encode(op_intl, reg_idx_t'(r), '0, 1'b1, v[k*8 +: 8], fn_bis,
                        reg_idx_t'(r)), 0);
         end
      end
      send(encode(op_inta, reg_idx_t'(reg_zero), '0, 1'b1, 8'd1, fn_subq, 5'd15), 0);
      send(encode(op_inta, reg_idx_t'(reg_zero), '0, 1'b1, 8'd200, fn_addq,
                  reg_idx_t'(reg_zero)), 1);
      send(encode(op_ints, 5'd1, '0, 1'b1, 8'd200, fn_srl, 5'd16), 0);
      send(encode(op_inta, reg_idx_t'(reg_zero), 5'd15, 1'b0, 8'h00, fn_addq, 5'd17), 0);
      drain();
      report_test("literal operands", err_before);
   endtask

   task automatic test_random(input string name, input int group, input int count,
                              input logic odd);
      int err_before;
      int g;
      err_before = errors;
      for (int i = 0; i < count; i++)
      begin
         g = (group < 0) ? $urandom_range(0, 2) : group;
         send(gen_instn(g, odd), pick_gap());
      end
      drain();
      report_test(name, err_before);
   endtask

   initial
   begin
      void'($urandom(2005));
      rst          = 1'b1;
      instn_vld    = 1'b0;
      instn        = '0;
      errors       = 0;
      checks       = 0;
      tests_run    = 0;
      tests_failed = 0;
      timed_out    = 1'b0;
      busy_cycle   = '0;
      busy_wr      = 1'b0;
      busy_rc      = '0;
      for (int i = 0; i < nreg; i++)
         model_rf[i] = '0;
      repeat (2) @(posedge clk);
      #1;
      rst = 1'b0;

      test_reset_idle();
      test_literal_build();
      test_random("add and compare", 0, 150, 1'b0);
      test_random("logical", 1, 150, 1'b0);
      test_random("shift", 2, 150, 1'b0);
      test_random("mixed stream", -1, 300, 1'b1);

      $display("tests run %0d, passed %0d, failed %0d, checks %0d, errors %0d",
               tests_run, tests_run - tests_failed, tests_failed, checks, errors);
      if (errors == 0 && tests_failed == 0 && !timed_out)
         $display("ALL TESTS PASSED");
      else
         $display("SOME TESTS FAILED");
      $finish;
   end

endmodule

`default_nettype wire
